/* src/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  ////////////////////////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////////////////////////
  typedef logic [15:0] word_t;    // Data word
  typedef logic [15:0] addr_t;    // Word address, imem and dmem alike
  typedef logic [3:0]  reg_id_t;  // Register number

  localparam int    DMEM_DEPTH = 256;                 // Data memory words
  localparam int    DMEM_AW    = $clog2(DMEM_DEPTH);  // Index bits taken from the address
  localparam int    REG_COUNT  = 16;                  // r0 reads as zero
  localparam addr_t RESET_PC   = 16'h0000;

  ////////////////////////////////////////////////////////////
  // Instruction encoding
  ////////////////////////////////////////////////////////////
  // Opcode sits in instr[15:12]
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,  // rd[11:8] rs[7:4] rt[3:0], sets Z N V
    OP_SUB = 4'h1,  // Same format as ADD
    OP_XOR = 4'h2,  // Same format, sets Z only
    OP_LW  = 4'h8,  // rd[11:8] rs[7:4] off[3:0], addr is rs + sext(off)
    OP_SW  = 4'h9,  // Data register in [11:8], address as LW
    OP_LLB = 4'hA,  // rd[11:8] imm[7:0] sign extended
    OP_B   = 4'hC,  // cond[11:9] off[8:0], target pc + 1 + sext(off)
    OP_BR  = 4'hD,  // cond[11:9] rs[7:4], target is rs
    OP_HLT = 4'hF
  } opcode_t;

  // Branch condition in instr[11:9]
  typedef enum logic [2:0] {
    COND_NE = 3'b000,  // Z clear
    COND_EQ = 3'b001,  // Z set
    COND_GT = 3'b010,  // Z and N clear
    COND_LT = 3'b011,  // N set
    COND_GE = 3'b100,  // Z set or N clear
    COND_LE = 3'b101,  // N or Z set
    COND_OV = 3'b110,  // V set
    COND_AL = 3'b111   // Unconditional
  } cond_t;

  typedef struct packed {
    logic z;
    logic n;
    logic v;
  } flags_t;

  ////////////////////////////////////////////////////////////
  // Control and pipeline registers
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic    reg_write;
    logic    mem_en;      // LW or SW
    logic    mem_write;   // SW
    opcode_t alu_op;
    logic    sets_zero;   // Z enable
    logic    sets_nv;     // N and V enable
    logic    halt;
    logic    valid;       // Clear for a bubble
  } ctrl_t;

  typedef struct packed {
    addr_t   pc;
    ctrl_t   ctrl;
    reg_id_t rd;
    reg_id_t rs;
    reg_id_t rt;
    word_t   op_a;
    word_t   op_b;
    word_t   imm;
  } id_ex_t;

  typedef struct packed {
    addr_t   pc;
    ctrl_t   ctrl;
    reg_id_t rd;
    reg_id_t rt;
    word_t   result;   // ALU value or memory address
    word_t   st_data;
  } ex_mem_t;

  typedef struct packed {
    addr_t   pc;
    ctrl_t   ctrl;
    reg_id_t rd;
    word_t   wdata;     // Zero unless reg_write
    addr_t   mem_addr;  // Zero unless a store
    word_t   mem_data;
  } mem_wb_t;

  typedef struct packed {
    logic    valid;
    addr_t   pc;
    logic    reg_write;
    reg_id_t rd;
    word_t   data;
    logic    mem_write;
    addr_t   mem_addr;
    word_t   mem_data;
    logic    halt;
  } retire_t;

endpackage

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  input  wire        pc_stall,       // Hold the PC
  input  wire        if_id_stall,    // Hold IF/ID
  input  wire        if_flush,       // Drop the fetched instruction
  input  wire        branch_taken,
  input  wire addr_t branch_target,
  input  wire        halt_seen,      // HLT in decode
  output addr_t      imem_addr,
  input  wire word_t imem_data,      // Combinational return
  output addr_t      if_id_pc,
  output word_t      if_id_instr,
  output logic       if_id_valid
);

  addr_t pc;       // Fetch address
  logic  stopped;  // Set once HLT has left decode

  assign imem_addr = pc;

  // PC and next-PC select
  always_ff @(posedge clk) begin
    if (rst) begin
      pc      <= RESET_PC;
      stopped <= 1'b0;
    end else begin
      if (halt_seen)
        stopped <= 1'b1;
      if (branch_taken)
        pc <= branch_target;  // Predicted not taken, redirect now
      else if (!(pc_stall || halt_seen || stopped))
        pc <= pc + 16'd1;
    end
  end

  // IF/ID valid bit, a bubble after flush or halt
  always_ff @(posedge clk) begin
    if (rst)
      if_id_valid <= 1'b0;
    else if (!if_id_stall)
      if_id_valid <= !(if_flush || halt_seen || stopped);
  end

  always_ff @(posedge clk) begin
    if (!if_id_stall) begin
      if_id_pc    <= pc;
      if_id_instr <= imem_data;
    end
  end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import cpu_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire addr_t   if_id_pc,
  input  wire word_t   if_id_instr,
  input  wire          if_id_valid,
  input  wire          id_flush,       // Bubble into ID/EX
  input  wire          if_id_stall,    // Branches wait while set
  input  wire mem_wb_t wb,             // Register file write port
  input  wire flags_t  flags,          // Flag register in execute
  output reg_id_t      src_rs,         // Zero when not read
  output reg_id_t      src_rt,
  output logic         is_store,
  output logic         is_b,
  output logic         is_br,
  output logic         branch_taken,
  output addr_t        branch_target,
  output logic         halt_seen,
  output id_ex_t       id_ex
);

  word_t   regs [REG_COUNT];  // Entry 0 never written
  opcode_t op;
  cond_t   cond;
  logic    is_alu;     // ADD SUB XOR
  logic    is_load;
  logic    is_llb;
  logic    is_hlt;
  logic    cond_true;
  reg_id_t dst;        // Zero for non-writers
  word_t   rs_val;
  word_t   rt_val;
  word_t   imm;
  ctrl_t   ctrl;

  assign op   = opcode_t'(if_id_instr[15:12]);
  assign cond = cond_t'(if_id_instr[11:9]);

  // Opcode classes, a bubble decodes to none of them
  assign is_alu   = if_id_valid && (op inside {OP_ADD, OP_SUB, OP_XOR});
  assign is_load  = if_id_valid && op == OP_LW;
  assign is_store = if_id_valid && op == OP_SW;
  assign is_llb   = if_id_valid && op == OP_LLB;
  assign is_b     = if_id_valid && op == OP_B;
  assign is_br    = if_id_valid && op == OP_BR;
  assign is_hlt   = if_id_valid && op == OP_HLT;
  assign halt_seen = is_hlt;

  assign src_rs = (is_alu || is_load || is_store || is_br) ? if_id_instr[7:4] : '0;
  assign src_rt = is_alu ? if_id_instr[3:0] : (is_store ? if_id_instr[11:8] : '0);
  assign dst    = (is_alu || is_load || is_llb) ? if_id_instr[11:8] : '0;
  assign imm    = is_llb ? {{8{if_id_instr[7]}}, if_id_instr[7:0]}
                         : {{12{if_id_instr[3]}}, if_id_instr[3:0]};  // LW and SW offset

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wb.ctrl.reg_write && wb.rd != '0)
      regs[wb.rd] <= wb.wdata;
  end

  // Write-first read, writeback value bypasses the array
  always_comb begin
    rs_val = regs[src_rs];
    rt_val = regs[src_rt];
    if (wb.ctrl.reg_write && wb.rd == src_rs)
      rs_val = wb.wdata;
    if (wb.ctrl.reg_write && wb.rd == src_rt)
      rt_val = wb.wdata;
    if (src_rs == '0)
      rs_val = '0;  // r0 is hardwired
    if (src_rt == '0)
      rt_val = '0;
  end

  ////////////////////////////////////////////////////////////
  // Branch resolution
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (cond)
      COND_NE: cond_true = !flags.z;
      COND_EQ: cond_true = flags.z;
      COND_GT: cond_true = !flags.z && !flags.n;
      COND_LT: cond_true = flags.n;
      COND_GE: cond_true = flags.z || !flags.n;
      COND_LE: cond_true = flags.n || flags.z;
      COND_OV: cond_true = flags.v;
      default: cond_true = 1'b1;  // COND_AL
    endcase
  end

  assign branch_taken  = (is_b || is_br) && cond_true && !if_id_stall;
  assign branch_target = is_br ? rs_val
                               : if_id_pc + 16'd1 + {{7{if_id_instr[8]}}, if_id_instr[8:0]};

  // Control word
  always_comb begin
    ctrl           = '0;
    ctrl.valid     = if_id_valid;  // Branches and HLT retire too
    ctrl.alu_op    = op;
    ctrl.reg_write = is_alu || is_load || is_llb;
    ctrl.mem_en    = is_load || is_store;
    ctrl.mem_write = is_store;
    ctrl.sets_zero = is_alu;
    ctrl.sets_nv   = is_alu && op != OP_XOR;
    ctrl.halt      = is_hlt;
  end

  // ID/EX register
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex.pc   <= if_id_pc;
      id_ex.ctrl <= id_flush ? ctrl_t'('0) : ctrl;  // Stalled instruction stays in decode
      id_ex.rd   <= dst;
      id_ex.rs   <= src_rs;
      id_ex.rt   <= src_rt;
      id_ex.op_a <= rs_val;
      id_ex.op_b <= rt_val;
      id_ex.imm  <= imm;
    end
  end

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
  input  wire reg_id_t id_ex_rd,
  input  wire reg_id_t ex_mem_rd,
  input  wire reg_id_t src_rs,            // Decode sources
  input  wire reg_id_t src_rt,
  input  wire          id_ex_reg_write,
  input  wire          ex_mem_reg_write,
  input  wire          id_ex_mem_en,
  input  wire          id_ex_mem_write,
  input  wire          is_store,          // SW in decode
  input  wire          is_b,
  input  wire          is_br,
  input  wire          id_ex_sets_zero,
  input  wire          id_ex_sets_nv,
  input  wire          branch_taken,
  output logic         pc_stall,
  output logic         if_id_stall,
  output logic         id_flush,          // Bubble into ID/EX
  output logic         if_flush           // Kill the fetched instruction
);

  logic id_ex_load;  // LW in execute
  logic load_use;
  logic flag_haz;    // Flags not yet written for a branch
  logic br_ex_haz;   // BR source produced in execute
  logic br_mem_haz;  // BR source produced in memory
  logic stall;

  ////////////////////////////////////////////////////////////
  // Hazard terms
  ////////////////////////////////////////////////////////////
  assign id_ex_load = id_ex_mem_en && !id_ex_mem_write;

  // Store data from a load goes through MEM to MEM forwarding instead
  assign load_use = id_ex_load && id_ex_rd != '0 &&
                    (id_ex_rd == src_rs || (id_ex_rd == src_rt && !is_store));

  assign flag_haz = (is_b || is_br) && (id_ex_sets_zero || id_ex_sets_nv);

  // Writeback value reaches decode through the register file bypass
  assign br_ex_haz  = is_br && id_ex_reg_write && id_ex_rd != '0 && id_ex_rd == src_rs;
  assign br_mem_haz = is_br && ex_mem_reg_write && ex_mem_rd != '0 && ex_mem_rd == src_rs;

  assign stall = load_use || flag_haz || br_ex_haz || br_mem_haz;

  // Outputs
  assign pc_stall    = stall;
  assign if_id_stall = stall;
  assign id_flush    = stall;                    // Decode instruction waits, bubble goes on
  assign if_flush    = branch_taken && !stall;   // Not-taken prediction missed

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import cpu_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire id_ex_t  id_ex,
  output ex_mem_t      ex_mem,
  input  wire mem_wb_t mem_wb,   // Older forwarding source
  output flags_t       flags     // Read by decode for branches
);

  word_t op_a;
  word_t op_b;
  word_t sum;
  word_t diff;
  word_t result;
  logic  ovf;          // Signed overflow of ADD or SUB
  logic  ex_mem_load;  // Its result is only an address

  assign ex_mem_load = ex_mem.ctrl.mem_en && !ex_mem.ctrl.mem_write;

  ////////////////////////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////////////////////////
  // Youngest producer wins, r0 never forwarded
  function automatic word_t fwd(reg_id_t id, word_t val);
    if (id == '0)
      return val;
    if (ex_mem.ctrl.reg_write && ex_mem.rd == id && !ex_mem_load)
      return ex_mem.result;
    if (mem_wb.ctrl.reg_write && mem_wb.rd == id)
      return mem_wb.wdata;
    return val;
  endfunction

  always_comb begin
    op_a = fwd(id_ex.rs, id_ex.op_a);
    op_b = fwd(id_ex.rt, id_ex.op_b);  // Store data too
  end

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////
  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    result = '0;
    ovf    = 1'b0;
    case (id_ex.ctrl.alu_op)
      OP_ADD: begin
        result = sum;
        ovf    = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
      end
      OP_SUB: begin
        result = diff;
        ovf    = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);
      end
      OP_XOR:       result = op_a ^ op_b;
      OP_LLB:       result = id_ex.imm;
      OP_LW, OP_SW: result = op_a + id_ex.imm;  // Word address
      default:      result = '0;                // Branches and HLT
    endcase
  end

  // Flag register, each flag under its own enable
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
    end else begin
      if (id_ex.ctrl.sets_zero)
        flags.z <= (result == '0);
      if (id_ex.ctrl.sets_nv) begin
        flags.n <= result[15];
        flags.v <= ovf;
      end
    end
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem.ctrl <= '0;
    end else begin
      ex_mem.pc      <= id_ex.pc;
      ex_mem.ctrl    <= id_ex.ctrl;
      ex_mem.rd      <= id_ex.rd;
      ex_mem.rt      <= id_ex.rt;
      ex_mem.result  <= result;
      ex_mem.st_data <= op_b;
    end
  end

endmodule

`default_nettype wire

/* src/memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_stage import cpu_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire ex_mem_t ex_mem,
  output mem_wb_t      mem_wb,
  output retire_t      retire,
  output logic         halted   // Sticky until reset
);

  word_t              dmem [DMEM_DEPTH];
  logic [DMEM_AW-1:0] dmem_idx;  // Address wraps on the low bits
  logic               is_load;
  word_t              ld_data;
  word_t              st_data;

  assign dmem_idx = ex_mem.result[DMEM_AW-1:0];
  assign is_load  = ex_mem.ctrl.mem_en && !ex_mem.ctrl.mem_write;
  assign ld_data  = dmem[dmem_idx];  // Asynchronous read

  // A load now in writeback feeds the store right behind it
  assign st_data = (ex_mem.ctrl.mem_write && ex_mem.rt != '0 &&
                    mem_wb.ctrl.reg_write && mem_wb.rd == ex_mem.rt) ? mem_wb.wdata
                                                                      : ex_mem.st_data;

  always_ff @(posedge clk) begin
    if (ex_mem.ctrl.mem_write)
      dmem[dmem_idx] <= st_data;
  end

  ////////////////////////////////////////////////////////////
  // MEM/WB register and halt
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb.ctrl <= '0;
      halted      <= 1'b0;
    end else begin
      mem_wb.pc       <= ex_mem.pc;
      mem_wb.ctrl     <= ex_mem.ctrl;
      mem_wb.rd       <= ex_mem.rd;
      mem_wb.wdata    <= is_load ? ld_data : (ex_mem.ctrl.reg_write ? ex_mem.result : '0);
      mem_wb.mem_addr <= ex_mem.ctrl.mem_write ? ex_mem.result : '0;
      mem_wb.mem_data <= ex_mem.ctrl.mem_write ? st_data : '0;
      if (ex_mem.ctrl.halt)
        halted <= 1'b1;  // Same edge HLT enters writeback
    end
  end

  // Retire stream straight from MEM/WB
  always_comb begin
    retire.valid     = mem_wb.ctrl.valid;
    retire.pc        = mem_wb.pc;
    retire.reg_write = mem_wb.ctrl.reg_write;
    retire.rd        = mem_wb.rd;
    retire.data      = mem_wb.wdata;
    retire.mem_write = mem_wb.ctrl.mem_write;
    retire.mem_addr  = mem_wb.mem_addr;
    retire.mem_data  = mem_wb.mem_data;
    retire.halt      = mem_wb.ctrl.halt;
  end

endmodule

`default_nettype wire

/* src/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
  input  wire        clk,
  input  wire        rst,
  output addr_t      imem_addr,
  input  wire word_t imem_data,
  output retire_t    retire,
  output logic       halted
);

  // IF/ID
  addr_t   if_id_pc;
  word_t   if_id_instr;
  logic    if_id_valid;
  // Stage registers
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;   // Also the register file write port
  flags_t  flags;
  // Decode to hazard unit and fetch
  reg_id_t src_rs;
  reg_id_t src_rt;
  logic    is_store;
  logic    is_b;
  logic    is_br;
  logic    branch_taken;
  addr_t   branch_target;
  logic    halt_seen;
  // Hazard controls
  logic    pc_stall;
  logic    if_id_stall;
  logic    id_flush;
  logic    if_flush;

  ////////////////////////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////////////////////////
  fetch_stage u_fetch (
    .clk, .rst, .pc_stall, .if_id_stall, .if_flush,
    .branch_taken, .branch_target, .halt_seen,
    .imem_addr, .imem_data,
    .if_id_pc, .if_id_instr, .if_id_valid
  );

  decode_stage u_decode (
    .clk, .rst, .if_id_pc, .if_id_instr, .if_id_valid,
    .id_flush, .if_id_stall,
    .wb       (mem_wb),
    .flags,
    .src_rs, .src_rt, .is_store, .is_b, .is_br,
    .branch_taken, .branch_target, .halt_seen,
    .id_ex
  );

  hazard_unit u_hazard (
    .id_ex_rd         (id_ex.rd),
    .ex_mem_rd        (ex_mem.rd),
    .src_rs, .src_rt,
    .id_ex_reg_write  (id_ex.ctrl.reg_write),
    .ex_mem_reg_write (ex_mem.ctrl.reg_write),
    .id_ex_mem_en     (id_ex.ctrl.mem_en),
    .id_ex_mem_write  (id_ex.ctrl.mem_write),
    .is_store, .is_b, .is_br,
    .id_ex_sets_zero  (id_ex.ctrl.sets_zero),
    .id_ex_sets_nv    (id_ex.ctrl.sets_nv),
    .branch_taken,
    .pc_stall, .if_id_stall, .id_flush, .if_flush
  );

  execute_stage u_execute (
    .clk, .rst, .id_ex, .ex_mem, .mem_wb, .flags
  );

  memory_stage u_memory (
    .clk, .rst, .ex_mem, .mem_wb, .retire, .halted
  );

endmodule

`default_nettype wire

/* verif/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import cpu_pkg::*; (
  input wire          clk,
  input wire          rst,
  input wire addr_t   imem_addr,   // Fetch address, frozen once HLT is decoded
  input wire retire_t retire,
  input wire          halted
);

  localparam int PROG_MAX = 128;

  // Instruction-level model state
  word_t   prog [PROG_MAX];
  word_t   regs [REG_COUNT];   // r0 never written
  word_t   dmem [DMEM_DEPTH];
  addr_t   mpc;
  logic    fz;
  logic    fn;
  logic    fv;
  logic    done;               // Model has executed HLT
  logic    active;             // A program is loaded
  logic    reported;           // Program line printed
  retire_t expect_r;

  int      prog_num;
  int      prog_errors;
  int      prog_retired;
  int      errors;
  int      programs;
  int      retired;

  initial begin
    errors   = 0;
    programs = 0;
    retired  = 0;
    active   = 1'b0;
    done     = 1'b0;
    reported = 1'b0;
  end

  task automatic set_word(input int addr, input word_t w);
    prog[addr] = w;
  endtask

  task automatic start_program(input int num);
    for (int i = 0; i < REG_COUNT; i++)
      regs[i] = '0;
    for (int i = 0; i < DMEM_DEPTH; i++)
      dmem[i] = '0;
    mpc          = RESET_PC;
    fz           = 1'b0;  // Flags come out of reset clear
    fn           = 1'b0;
    fv           = 1'b0;
    done         = 1'b0;
    reported     = 1'b0;
    prog_num     = num;
    prog_errors  = 0;
    prog_retired = 0;
    active       = 1'b1;
  endtask

  function automatic logic cond_holds(input logic [2:0] c);
    case (cond_t'(c))
      COND_NE: return !fz;
      COND_EQ: return fz;
      COND_GT: return !fz && !fn;
      COND_LT: return fn;
      COND_GE: return fz || !fn;
      COND_LE: return fn || fz;
      COND_OV: return fv;
      default: return 1'b1;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // One instruction of the model, result left in expect_r
  ////////////////////////////////////////////////////////////
  task automatic step_model();
    word_t   ins;
    word_t   a;
    word_t   b;
    word_t   r;
    word_t   addr;
    reg_id_t rd;
    opcode_t op;
    int      sa;
    int      sb;
    int      s;
    ins  = prog[mpc[6:0]];
    op   = opcode_t'(ins[15:12]);
    rd   = ins[11:8];
    a    = regs[ins[7:4]];
    b    = regs[ins[3:0]];
    addr = a + {{12{ins[3]}}, ins[3:0]};  // LW and SW word address
    sa   = $signed(a);
    sb   = $signed(b);
    r    = '0;
    expect_r       = '0;
    expect_r.valid = 1'b1;
    expect_r.pc    = mpc;
    mpc            = mpc + 16'd1;
    case (op)
      OP_ADD, OP_SUB: begin
        s  = (op == OP_ADD) ? sa + sb : sa - sb;  // Exact signed result
        r  = s[15:0];
        fn = r[15];
        fv = (s > 32767) || (s < -32768);
        fz = (r == 16'h0000);
        expect_r.reg_write = 1'b1;
      end
      OP_XOR: begin
        r  = a ^ b;
        fz = (r == 16'h0000);  // N and V keep their values
        expect_r.reg_write = 1'b1;
      end
      OP_LLB: begin
        r = {{8{ins[7]}}, ins[7:0]};
        expect_r.reg_write = 1'b1;
      end
      OP_LW: begin
        r = dmem[addr[7:0]];
        expect_r.reg_write = 1'b1;
      end
      OP_SW: begin
        expect_r.mem_write = 1'b1;
        expect_r.mem_addr  = addr;
        expect_r.mem_data  = regs[rd];
        dmem[addr[7:0]]    = regs[rd];
      end
      OP_B: begin
        if (cond_holds(ins[11:9]))
          mpc = expect_r.pc + 16'd1 + {{7{ins[8]}}, ins[8:0]};
      end
      OP_BR: begin
        if (cond_holds(ins[11:9]))
          mpc = a;  // Register target
      end
      OP_HLT: begin
        expect_r.halt = 1'b1;
        done          = 1'b1;
        mpc           = expect_r.pc;
      end
      default: begin
        $display("%0t: model met an undefined opcode at pc %h", $time, expect_r.pc);
        errors++;
        prog_errors++;
      end
    endcase
    if (expect_r.reg_write) begin
      expect_r.rd   = rd;
      expect_r.data = r;
      if (rd != '0)
        regs[rd] = r;
    end
  endtask

  task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      $display("MISMATCH time=%0t signal=retire.%0s expected=%h actual=%h",
               $time, name, exp, act);
      errors++;
      prog_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Retire monitor
  ////////////////////////////////////////////////////////////
  // Sampled on the falling edge, half a cycle after the stage registers move
  always @(negedge clk) begin
    if (!rst && active) begin
      if (retire.valid === 1'b1) begin
        if (done) begin
          $display("%0t: retire event at pc %h after the program had halted",
                   $time, retire.pc);
          errors++;
          prog_errors++;
        end else begin
          step_model();
          compare("pc",        expect_r.pc,        retire.pc);
          compare("reg_write", expect_r.reg_write, retire.reg_write);
          compare("rd",        expect_r.rd,        retire.rd);
          compare("data",      expect_r.data,      retire.data);
          compare("mem_write", expect_r.mem_write, retire.mem_write);
          compare("mem_addr",  expect_r.mem_addr,  retire.mem_addr);
          compare("mem_data",  expect_r.mem_data,  retire.mem_data);
          compare("halt",      expect_r.halt,      retire.halt);
          prog_retired++;
          retired++;
        end
      end
      if (halted === 1'b1 && !reported) begin
        if (!done) begin
          $display("%0t: halted rose before the model reached HLT", $time);
          errors++;
          prog_errors++;
        end else if (imem_addr !== mpc + 16'd1) begin  // Fetch parks one past HLT
          $display("MISMATCH time=%0t signal=imem_addr expected=%h actual=%h",
                   $time, mpc + 16'd1, imem_addr);
          errors++;
          prog_errors++;
        end
        $display("program %0d: %0d retired, %0d errors", prog_num, prog_retired, prog_errors);
        programs++;
        reported = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verif/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpu_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int DRIVE_DELAY     = 2;    // Inputs move this long after the rising edge
  localparam int RESET_CYCLES    = 10;
  localparam int NUM_PROGS       = 24;
  localparam int PROG_LEN        = 64;   // HLT sits in the last slot
  localparam int PROG_MAX        = 128;  // Instruction memory window
  localparam int HLT_IDX         = PROG_LEN - 1;
  localparam int WATCHDOG_CYCLES = NUM_PROGS * (PROG_LEN * 8 + RESET_CYCLES + 8);

  logic    clk;
  logic    rst;
  addr_t   imem_addr;
  word_t   imem_data;
  retire_t retire;
  logic    halted;

  word_t   prog [PROG_MAX];  // Instruction memory model
  int      wr_ptr;           // Next free slot while building
  integer  seed;

  cpu_core uut (
    .clk, .rst, .imem_addr, .imem_data, .retire, .halted
  );

  tb_checker u_check (
    .clk, .rst, .imem_addr, .retire, .halted
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // PC only moves on the edge, so the fetch word is settled well before the next one
  always @(posedge clk) begin
    #DRIVE_DELAY;
    imem_data = prog[imem_addr[6:0]];
  end

  ////////////////////////////////////////////////////////////
  // Program generator
  ////////////////////////////////////////////////////////////
  function automatic int pick(input int range);
    return $unsigned($random(seed)) % range;
  endfunction

  task automatic emit(input word_t w);
    prog[wr_ptr] = w;
    wr_ptr++;
  endtask

  task automatic random_alu(input int rd);
    opcode_t op;
    case (pick(3))
      0:       op = OP_ADD;
      1:       op = OP_SUB;
      default: op = OP_XOR;
    endcase
    emit({op, 4'(rd), 4'(pick(7)), 4'(pick(7))});  // Sources r0..r6
  endtask

  task automatic build_program();
    int kind;
    int k;
    int rx;
    int f;
    for (int i = 0; i < PROG_MAX; i++)
      prog[i] = {4'hF, 5'h00, 7'(i)};  // HLT fill, low bits follow the address
    wr_ptr = 0;
    // r1..r6 get signed bytes, r7 is the load and store base
    for (int r = 1; r <= 6; r++)
      emit({OP_LLB, 4'(r), 8'(pick(256))});
    emit({OP_LLB, 4'd7, 8'(32 + pick(64))});
    // Words base-4 .. base+3 defined before any load
    for (int j = 0; j < 8; j++)
      emit({OP_SW, 4'(1 + j % 6), 4'd7, 4'(j - 4)});
    while (wr_ptr <= HLT_IDX - 6) begin  // Largest group is six words
      kind = pick(11);
      case (kind)
        0, 1, 2, 3: random_alu(pick(7));
        4: emit({OP_LLB, 4'(pick(7)), 8'(pick(256))});
        5: emit({OP_LW, 4'(pick(7)), 4'd7, 4'(pick(8) - 4)});
        6: emit({OP_SW, 4'(pick(7)), 4'd7, 4'(pick(8) - 4)});
        7: begin  // Load, then store of the same register
          rx = pick(7);
          emit({OP_LW, 4'(rx), 4'd7, 4'(pick(8) - 4)});
          emit({OP_SW, 4'(rx), 4'd7, 4'(pick(8) - 4)});
        end
        8: begin
          random_alu(pick(7));  // Flag setter right before the branch
          k = pick(4);
          emit({OP_B, 3'(pick(8)), 9'(k)});
          for (int j = 0; j < k; j++)
            random_alu(pick(7));  // Plain slots that a taken B skips
        end
        9: begin
          rx = 1 + pick(6);
          f  = pick(2);   // One or two slots between LLB and BR
          k  = pick(4);
          emit({OP_LLB, 4'(rx), 8'(wr_ptr + 2 + f + k)});  // Target just past the skipped slots
          if (f == 1)
            random_alu(rx % 6 + 1);  // Never rx itself
          emit({OP_BR, 3'(pick(8)), 1'b0, 4'(rx), 4'h0});
          for (int j = 0; j < k; j++)
            random_alu(pick(7));
        end
        default: random_alu(0);  // Results aimed at r0
      endcase
    end
    while (wr_ptr < HLT_IDX)
      random_alu(pick(7));
    emit({OP_HLT, 12'h000});
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    seed      = 32'h1408;
    rst       = 1'b1;
    imem_data = '0;
    wr_ptr    = 0;
    for (int p = 0; p < NUM_PROGS; p++) begin
      @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b1;
      build_program();
      for (int i = 0; i < PROG_MAX; i++)
        u_check.set_word(i, prog[i]);  // Same image for the model
      u_check.start_program(p);
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      while (halted !== 1'b1)
        @(posedge clk);
      repeat (4) @(posedge clk);  // A stray retire after HLT would show up here
    end
    $display("programs %0d of %0d, retire events %0d, errors %0d",
             u_check.programs, NUM_PROGS, u_check.retired, u_check.errors);
    if (u_check.errors == 0 && u_check.programs == NUM_PROGS)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog, scaled to program count and length
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, core did not reach HLT", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/hazard_unit.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_core.sv
verif/tb_checker.sv
verif/tb_top.sv
